/* files.f */
src/sdramPkg.sv
src/hostBusPkg.sv
src/delayTimer.sv
src/refreshTimer.sv
src/sdramSequencer.sv
src/byteLane.sv
src/sdramCtrlTop.sv
test/sdramModel.sv
test/tbSdramCtrl.sv

/* test/tbSdramCtrl.sv */
`timescale 1ns/100ps

module tbSdramCtrl;

    import sdramPkg::*;
    import hostBusPkg::*;

    // Short power-up wait and refresh interval, the rest as for the real part
    localparam sdramTimingT tbTiming = '{
        initWait:        16'd40,
        trp:             16'd2,
        trfc:            16'd7,
        tmrd:            16'd2,
        trcd:            16'd2,
        refreshInterval: 16'd120
    };

    localparam int clkPeriod   = 4;
    localparam int numPatterns = 6;
    localparam int randomOps   = 200;
    localparam int idleCycles  = 6 * tbTiming.refreshInterval;
    localparam int numOps      = 2 + 1 + 2 * numPatterns + randomOps;
    localparam int opCycles    = tbTiming.trcd + tbTiming.trp + tbTiming.trfc + 16;
    localparam int watchdogNs  = 2 * clkPeriod
                                 * (tbTiming.initWait + numOps * opCycles + idleCycles);

    logic     clk;
    logic     RESETn;
    logic     reqValid;
    hostReqT  req;
    logic     ready;
    hostWordT rdData;
    sdramBusT sdram;
    dqT       dqOut;
    logic     dqOe;
    dqT       dqIn;
    int       refreshCount;
    int       protoErrors;

    int       errors = 0;
    int       checks = 0;
    int       cycle = 0;                        // Cycles since reset release
    int       ckeRise = -1;
    sdramBusT cmdLog [$];                       // Every non-NOP command seen
    int       cmdCycle [$];
    hostWordT shadow [hostAddrT];               // Expected memory contents
    hostAddrT written [$];
    hostWordT expQ [$];                         // Expected words of open reads

    sdramCtrlTop #(
        .timing (tbTiming)
    ) dut (
        .clk      (clk),
        .RESETn   (RESETn),
        .reqValid (reqValid),
        .req      (req),
        .ready    (ready),
        .rdData   (rdData),
        .sdram    (sdram),
        .dqOut    (dqOut),
        .dqOe     (dqOe),
        .dqIn     (dqIn)
    );

    sdramModel #(
        .timing (tbTiming)
    ) model (
        .clk          (clk),
        .sdram        (sdram),
        .dqOut        (dqOut),
        .dqOe         (dqOe),
        .dqIn         (dqIn),
        .refreshCount (refreshCount),
        .protoErrors  (protoErrors)
    );

    initial
        clk = 1'b0;

    always #(clkPeriod / 2) clk = ~clk;

    // Masked write result, enabled lanes from the new word
    function automatic hostWordT mergeWord(hostWordT oldWord, hostWordT newWord, byteEnT en);
        hostWordT result;
        result = oldWord;
        for (int lane = 0; lane < 4; lane++)
            if (en[lane])
                result[8*lane +: 8] = newWord[8*lane +: 8];
        return result;
    endfunction

    function automatic hostAddrT randAddr(bankT b);
        hostAddrT a;
        a = hostAddrT'($urandom);
        a[29:21] = '0;                          // Above the address map
        a[20:19] = b;
        return a;
    endfunction

    function automatic int findCmd(int from, sdramCmdT c);
        for (int i = from; i < cmdLog.size(); i++)
            if (cmdLog[i].cmd == c)
                return i;
        return -1;
    endfunction

    task automatic checkWord(string name, hostWordT got, hostWordT exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %0t ns %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkCmd(string name, sdramCmdT got, sdramCmdT exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %0t ns %s: got %s expected %s", $time, name, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic checkCount(string name, int got, int exp);
        checks++;
        if (got != exp)
        begin
            $display("FAIL %0t ns %s: got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expectTrue(bit ok, string what);
        checks++;
        if (!ok)
        begin
            $display("Error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic reportTest(string name, int errsAtStart);
        int n;
        n = errors + protoErrors - errsAtStart;
        if (n == 0)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, n);
    endtask

    // One host access, request held until the ready pulse
    task automatic access(logic wr, hostAddrT addr, byteEnT be, hostWordT data);
        if (wr)
        begin
            if (!shadow.exists(addr))
            begin
                written.push_back(addr);
                shadow[addr] = '0;              // Only full writes land here
            end
            shadow[addr] = mergeWord(shadow[addr], data, be);
        end
        else
            expQ.push_back(shadow[addr]);
        req      <= '{write: wr, addr: addr, byteEn: be, wrData: data};
        reqValid <= 1'b1;
        do
            @(negedge clk);
        while (!ready);
        reqValid <= 1'b0;
        @(negedge clk);
    endtask

    // Command log and cke watch
    always @(negedge clk)
    begin
        if (RESETn)
        begin
            cycle++;
            if (sdram.cke && ckeRise < 0)
                ckeRise = cycle;
            if (!sdram.cke && ckeRise >= 0)
                expectTrue(1'b0, "cke dropped after initialisation");
            if (sdram.cmd != cmdNop)
            begin
                cmdLog.push_back(sdram);
                cmdCycle.push_back(cycle);
            end
        end
    end

    // Read data check on the ready pulse
    always @(negedge clk)
    begin
        if (ready && !reqValid)
            expectTrue(1'b0, "ready pulse with no request pending");
        else if (ready && !req.write)
        begin
            if (expQ.size() == 0)
                expectTrue(1'b0, "read completed with no expected word queued");
            else
                checkWord("rdData", rdData, expQ.pop_front());
        end
    end

    initial
    begin
        #(watchdogNs);
        $display("Timeout: run still going after %0d ns", watchdogNs);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        int       logStart;
        int       idx;
        int       errsAtStart;
        int       startCount;
        int       startCycle;
        logic     wr;
        hostAddrT addr;
        byteEnT   be;
        void'($urandom(39));
        RESETn   = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        repeat (3)
            @(negedge clk);
        RESETn <= 1'b1;

        // Power-up sequence
        errsAtStart = 0;
        while (cmdLog.size() < 4)
            @(negedge clk);
        expectTrue(ckeRise >= tbTiming.initWait, "cke rose before the power-up wait ended");
        expectTrue(cmdCycle[0] >= ckeRise, "command issued before cke rose");
        checkCmd("init cmd 0", cmdLog[0].cmd, cmdPrecharge);
        checkCount("init precharge A10", cmdLog[0].addr[10], 1);
        checkCmd("init cmd 1", cmdLog[1].cmd, cmdAutoRefresh);
        checkCmd("init cmd 2", cmdLog[2].cmd, cmdAutoRefresh);
        checkCmd("init cmd 3", cmdLog[3].cmd, cmdLmr);
        checkCount("LMR addr", cmdLog[3].addr, modeWord);
        expectTrue(cmdCycle[2] - cmdCycle[1] > tbTiming.trfc, "too few NOPs after AREFRESH 1");
        expectTrue(cmdCycle[3] - cmdCycle[2] > tbTiming.trfc, "too few NOPs after AREFRESH 2");
        reportTest("init", errsAtStart);

        // Full write then read back, address split seen by the model
        errsAtStart = errors + protoErrors;
        addr     = 30'h001A_C3D5;
        logStart = cmdLog.size();
        access(1'b1, addr, 4'hF, 32'hA5C3_1E77);
        access(1'b0, addr, 4'hF, '0);
        idx = findCmd(logStart, cmdActive);
        expectTrue(idx >= 0, "no ACTIVE seen for the write");
        if (idx >= 0)
        begin
            checkCount("ACTIVE ba", cmdLog[idx].ba, addr[20:19]);
            checkCount("ACTIVE row", cmdLog[idx].addr, addr[18:7]);
        end
        idx = findCmd(logStart, cmdWrite);
        expectTrue(idx >= 0, "no WRITE seen for the write");
        if (idx >= 0)
        begin
            checkCount("WRITE ba", cmdLog[idx].ba, addr[20:19]);
            checkCount("WRITE col", cmdLog[idx].addr[8:0], {addr[6:0], 2'b00});
        end
        reportTest("full word", errsAtStart);

        // Byte masks over one word
        errsAtStart = errors + protoErrors;
        addr = 30'h000E_1234;
        access(1'b1, addr, 4'hF, 32'h1122_3344);
        for (int i = 0; i < numPatterns; i++)
        begin
            access(1'b1, addr, byteEnT'(i * 5 + 1), $urandom);   // 1, 6, b, 0, 5, a
            access(1'b0, addr, 4'hF, '0);
        end
        reportTest("masked write", errsAtStart);

        // Refresh with the host quiet
        errsAtStart = errors + protoErrors;
        logStart    = cmdLog.size();
        startCount  = refreshCount;
        startCycle  = cycle;
        repeat (idleCycles)
            @(negedge clk);
        expectTrue(refreshCount - startCount
                   >= (cycle - startCycle) / tbTiming.refreshInterval - 1,
                   "too few refreshes during idle");
        for (int i = logStart; i < cmdLog.size(); i++)
        begin
            if (cmdLog[i].cmd == cmdAutoRefresh)
            begin
                checkCmd("cmd before AREFRESH", cmdLog[i-1].cmd, cmdPrecharge);
                checkCount("refresh precharge A10", cmdLog[i-1].addr[10], 1);
            end
        end
        reportTest("idle refresh", errsAtStart);

        // Mixed traffic over all banks
        errsAtStart = errors + protoErrors;
        for (int i = 0; i < randomOps; i++)
        begin
            wr = (written.size() == 0) || $urandom_range(1, 0);
            if (!wr)
                access(1'b0, written[$urandom_range(written.size() - 1, 0)], 4'hF, '0);
            else if ($urandom_range(1, 0))
            begin
                addr = written[$urandom_range(written.size() - 1, 0)];
                be   = byteEnT'($urandom);
                access(1'b1, addr, be, $urandom);
            end
            else
                access(1'b1, randAddr(bankT'(i)), 4'hF, $urandom);  // New word, all lanes
        end
        repeat (4)
            @(negedge clk);
        reportTest("random", errsAtStart);

        $display("Tests: 5, checks: %0d, errors: %0d, protocol errors: %0d",
                 checks, errors, protoErrors);
        if (errors + protoErrors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* test/sdramModel.sv */
`timescale 1ns/100ps

module sdramModel #(
    parameter sdramPkg::sdramTimingT timing = sdramPkg::defaultTiming
) (
    input  logic               clk,
    input  sdramPkg::sdramBusT sdram,
    input  sdramPkg::dqT       dqOut,           // Controller write byte
    input  logic               dqOe,
    output sdramPkg::dqT       dqIn,            // Read byte back to the controller
    output int                 refreshCount,
    output int                 protoErrors
);

    import sdramPkg::*;

    dqT          mem [logic [22:0]];            // Keyed by {bank, row, column}
    logic [3:0]  rowOpen;
    rowT         openRow [4];
    int          activeAt [4];                  // Cycle of each bank's ACTIVE
    int          cycle;
    int          busyUntil;                     // First cycle a new command may come
    int          wrStage;
    int          rdStage;
    logic [22:0] wrBase;
    logic [22:0] rdBase;

    // Unwritten bytes read back a pattern of their full address
    function automatic dqT fillByte(logic [22:0] a);
        return a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]} ^ 8'h5A;
    endfunction

    task automatic violation(string what);
        $display("Protocol error at %0t ns: %s", $time, what);
        protoErrors++;
    endtask

    task automatic storeByte(int k);
        if (!dqOe)
            violation("write burst byte not driven on DQ");
        if (!sdram.dqm)
            mem[wrBase + 23'(k)] = dqOut;       // Masked lanes keep old data
    endtask

    initial
    begin
        dqIn         = 'z;
        rowOpen      = '0;
        cycle        = 0;
        busyUntil    = 0;
        wrStage      = 0;
        rdStage      = 0;
        refreshCount = 0;
        protoErrors  = 0;
    end

    always @(posedge clk)
    begin
        int k;
        cycle++;
        if (dqOe && wrStage == 0 && sdram.cmd != cmdWrite)
            violation("DQ driven outside a write burst");
        if (wrStage != 0)
        begin
            storeByte(wrStage);                 // Bytes 1 to 3 on the NOP cycles
            wrStage = (wrStage == burstBytes - 1) ? 0 : wrStage + 1;
        end
        if (rdStage != 0)
        begin
            k = rdStage - casLatency + 1;       // Byte due on DQ next cycle
            if (k >= burstBytes)
            begin
                dqIn    <= 'z;                  // Burst over, bus released
                rdStage = 0;
            end
            else
            begin
                if (k >= 0)
                    dqIn <= mem.exists(rdBase + 23'(k)) ? mem[rdBase + 23'(k)]
                                                        : fillByte(rdBase + 23'(k));
                rdStage++;
            end
        end
        if (sdram.cmd != cmdNop)
        begin
            if (!sdram.cke)
                violation("command issued while cke is low");
            if (cycle < busyUntil)
                violation($sformatf("%s issued inside a timed gap", sdram.cmd.name()));
            if (wrStage != 0 || rdStage != 0)
                violation("command issued during a data burst");
        end
        case (sdram.cmd)
            cmdActive:
            begin
                if (rowOpen[sdram.ba])
                    violation("ACTIVE to a bank whose row is already open");
                rowOpen[sdram.ba]  = 1'b1;
                openRow[sdram.ba]  = sdram.addr;
                activeAt[sdram.ba] = cycle;
            end
            cmdRead, cmdWrite:
            begin
                if (!rowOpen[sdram.ba] || cycle - activeAt[sdram.ba] <= timing.trcd)
                    violation("column access without a row open for trcd cycles");
                if (sdram.cmd == cmdWrite)
                begin
                    wrBase = {sdram.ba, openRow[sdram.ba], sdram.addr[8:0]};
                    storeByte(0);               // Byte 0 rides with WRITE
                    wrStage = 1;
                end
                else
                begin
                    rdBase  = {sdram.ba, openRow[sdram.ba], sdram.addr[8:0]};
                    rdStage = 1;
                end
            end
            cmdPrecharge:
            begin
                if (sdram.addr[10])
                    rowOpen = '0;               // A10 closes every bank
                else
                    rowOpen[sdram.ba] = 1'b0;
                busyUntil = cycle + timing.trp + 1;
            end
            cmdAutoRefresh:
            begin
                if (rowOpen != '0)
                    violation("AREFRESH while a row is open");
                refreshCount++;
                busyUntil = cycle + timing.trfc + 1;
            end
            cmdLmr:
            begin
                if (rowOpen != '0)
                    violation("LMR while a row is open");
                busyUntil = cycle + timing.tmrd + 1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

/* src/sdramCtrlTop.sv */
`timescale 1ns/100ps

module sdramCtrlTop #(
    parameter sdramPkg::sdramTimingT timing = sdramPkg::defaultTiming
) (
    input  logic                 clk,
    input  logic                 RESETn,
    input  logic                 reqValid,      // Held until ready
    input  hostBusPkg::hostReqT  req,
    output logic                 ready,         // One-cycle pulse per access
    output hostBusPkg::hostWordT rdData,        // Valid with ready on reads
    output sdramPkg::sdramBusT   sdram,
    output sdramPkg::dqT         dqOut,
    output logic                 dqOe,          // Board tristates DQ with this
    input  sdramPkg::dqT         dqIn
);

    import sdramPkg::*;
    import hostBusPkg::*;

    sdramCmdBusT cmdBus;
    hostWordT    wrData;
    byteEnT      byteEn;
    logic        refreshDue;
    logic        refreshAck;
    logic        initDone;
    logic        delayLoad;
    logic [15:0] delayCount;
    logic        delayDone;
    logic        write;
    logic        burstPhase;
    logic        captureStrobe;
    logic [1:0]  byteIndex;
    logic        dqm;

    assign sdram = {cmdBus, dqm};               // dqm is the last field of the bus

    sdramSequencer #(
        .timing (timing)
    ) u_sequencer (
        .clk           (clk),
        .RESETn        (RESETn),
        .reqValid      (reqValid),
        .req           (req),
        .ready         (ready),
        .refreshDue    (refreshDue),
        .refreshAck    (refreshAck),
        .initDone      (initDone),
        .delayLoad     (delayLoad),
        .delayCount    (delayCount),
        .delayDone     (delayDone),
        .cmdBus        (cmdBus),
        .write         (write),
        .burstPhase    (burstPhase),
        .captureStrobe (captureStrobe),
        .byteIndex     (byteIndex),
        .wrData        (wrData),
        .byteEn        (byteEn)
    );

    delayTimer u_delay (
        .clk    (clk),
        .RESETn (RESETn),
        .load   (delayLoad),
        .count  (delayCount),
        .done   (delayDone)
    );

    refreshTimer #(
        .timing (timing)
    ) u_refresh (
        .clk        (clk),
        .RESETn     (RESETn),
        .enable     (initDone),                 // Interval runs once init is over
        .ack        (refreshAck),
        .refreshDue (refreshDue)
    );

    byteLane u_lane (
        .clk           (clk),
        .RESETn        (RESETn),
        .write         (write),
        .burstPhase    (burstPhase),
        .captureStrobe (captureStrobe),
        .byteIndex     (byteIndex),
        .wrData        (wrData),
        .byteEn        (byteEn),
        .dqIn          (dqIn),
        .dqOut         (dqOut),
        .dqOe          (dqOe),
        .dqm           (dqm),
        .rdData        (rdData)
    );

endmodule

/* src/byteLane.sv */
`timescale 1ns/100ps

module byteLane (
    input  logic                 clk,
    input  logic                 RESETn,
    input  logic                 write,         // Latched request is a write
    input  logic                 burstPhase,    // Write byte goes out this cycle
    input  logic                 captureStrobe, // Read byte arrives this cycle
    input  logic [1:0]           byteIndex,     // Lane of the current byte
    input  hostBusPkg::hostWordT wrData,
    input  hostBusPkg::byteEnT   byteEn,
    input  sdramPkg::dqT         dqIn,
    output sdramPkg::dqT         dqOut,
    output logic                 dqOe,
    output logic                 dqm,
    output hostBusPkg::hostWordT rdData
);

    assign dqOut = wrData[8*byteIndex +: 8];            // Lane 0 first
    assign dqOe  = write && burstPhase;
    assign dqm   = burstPhase && !byteEn[byteIndex];    // Disabled lane masked, reads never

    // Read word built up lane by lane
    always_ff @(posedge clk)
    begin
        if (!RESETn)
        begin
            rdData <= '0;
        end
        else if (captureStrobe)
        begin
            rdData[8*byteIndex +: 8] <= dqIn;
        end
    end

    // Bus turnaround, DQ released at least a cycle before read data
    noDriveOnCapture: assert property (@(posedge clk) disable iff (!RESETn)
        captureStrobe |-> !dqOe && !$past(dqOe))
        else $error("byteLane: DQ driven during read capture of lane %0d", byteIndex);

endmodule

/* src/sdramSequencer.sv */
`timescale 1ns/100ps

module sdramSequencer #(
    parameter sdramPkg::sdramTimingT timing = sdramPkg::defaultTiming
) (
    input  logic                  clk,
    input  logic                  RESETn,
    input  logic                  reqValid,         // Level, held until ready
    input  hostBusPkg::hostReqT   req,
    output logic                  ready,            // One-cycle end of access
    input  logic                  refreshDue,
    output logic                  refreshAck,
    output logic                  initDone,
    output logic                  delayLoad,
    output logic [15:0]           delayCount,
    input  logic                  delayDone,
    output sdramPkg::sdramCmdBusT cmdBus,
    output logic                  write,
    output logic                  burstPhase,       // Write byte on DQ this cycle
    output logic                  captureStrobe,    // Read byte on DQ this cycle
    output logic [1:0]            byteIndex,
    output hostBusPkg::hostWordT  wrData,
    output hostBusPkg::byteEnT    byteEn
);

    import sdramPkg::*;
    import hostBusPkg::*;

    typedef enum logic [3:0] {
        stReset,                                    // Kicks off the power-up wait
        stInitPre,
        stInitRef1,
        stInitRef2,
        stInitLmr,
        stIdle,
        stRefPre,
        stRefRef,
        stActive,
        stWrite,
        stRead,
        stBurst,                                    // Write beats or read latency and capture
        stPre,                                      // Closes the row after an access
        stWait                                      // NOPs until delayTimer expires
    } stateT;

    localparam logic [2:0] firstCapture  = 3'(casLatency);
    localparam logic [2:0] lastReadBeat  = 3'(casLatency + burstBytes - 1);
    localparam logic [2:0] lastWriteBeat = 3'(burstBytes); // Beat 4 is the recovery NOP

    stateT      state;
    stateT      resumeState;                        // Target once the wait ends
    stateT      afterWait;                          // resumeState for this command
    hostReqT    reqLatch;                           // Request held for the access
    logic       accept;
    logic       accessOpen;                         // Between accept and ready
    logic       cke;
    logic       waitOver;
    logic [2:0] beat;                               // Cycles since WRITE/READ
    bankT       bank;
    rowT        row;
    colT        col;

    // Fixed address map
    assign bank = reqLatch.addr[20:19];
    assign row  = reqLatch.addr[18:7];
    assign col  = {reqLatch.addr[6:0], 2'b00};      // Burst starts at byte 0 of the word

    assign accept   = (state == stIdle) && !refreshDue && reqValid;
    assign waitOver = (state == stWait) && delayDone;

    // Every timed command loads the shared timer and parks in stWait
    always_comb
    begin
        delayLoad  = 1'b1;
        delayCount = timing.trp;
        afterWait  = stIdle;
        case (state)
            stReset:
            begin
                delayCount = timing.initWait;
                afterWait  = stInitPre;
            end
            stInitPre:  afterWait = stInitRef1;
            stInitRef1:
            begin
                delayCount = timing.trfc;
                afterWait  = stInitRef2;
            end
            stInitRef2:
            begin
                delayCount = timing.trfc;
                afterWait  = stInitLmr;
            end
            stInitLmr:  delayCount = timing.tmrd;
            stRefPre:   afterWait = stRefRef;
            stRefRef:   delayCount = timing.trfc;
            stActive:
            begin
                delayCount = timing.trcd;
                afterWait  = reqLatch.write ? stWrite : stRead;
            end
            stPre:      afterWait = stIdle;         // trp, then ready
            default:    delayLoad = 1'b0;           // Untimed states
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!RESETn)
        begin
            state       <= stReset;
            resumeState <= stIdle;
            accessOpen  <= 1'b0;
            cke         <= 1'b0;
            initDone    <= 1'b0;
            ready       <= 1'b0;
            beat        <= '0;
        end
        else
        begin
            ready <= waitOver && accessOpen && (resumeState == stIdle); // Closing trp over
            beat  <= (state inside {stWrite, stRead, stBurst}) ? beat + 3'd1 : 3'd0;
            if (delayLoad)
            begin
                state       <= stWait;
                resumeState <= afterWait;
            end
            else
            begin
                case (state)
                    stWait:
                    begin
                        if (delayDone)
                        begin
                            state <= resumeState;
                            if (resumeState == stInitPre)
                                cke <= 1'b1;        // Power-up wait over
                            if (resumeState == stIdle)
                            begin
                                initDone   <= 1'b1;
                                accessOpen <= 1'b0;
                            end
                        end
                    end
                    stIdle:
                    begin
                        if (refreshDue)
                            state <= stRefPre;      // Refresh beats a waiting request
                        else if (reqValid)
                        begin
                            state      <= stActive;
                            accessOpen <= 1'b1;
                        end
                    end
                    stWrite, stRead:
                        state <= stBurst;
                    stBurst:
                        if (beat == (reqLatch.write ? lastWriteBeat : lastReadBeat))
                            state <= stPre;
                    default:
                        state <= stIdle;            // Unused encodings
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            reqLatch <= req;
    end

    // Command pins decoded from state
    always_comb
    begin
        cmdBus.cke  = cke;
        cmdBus.cmd  = cmdNop;
        cmdBus.addr = '0;
        cmdBus.ba   = '0;
        case (state)
            stInitPre, stRefPre, stPre:
            begin
                cmdBus.cmd  = cmdPrecharge;
                cmdBus.addr = 12'h400;              // A10 high, all banks
            end
            stInitRef1, stInitRef2, stRefRef:
                cmdBus.cmd = cmdAutoRefresh;
            stInitLmr:
            begin
                cmdBus.cmd  = cmdLmr;
                cmdBus.addr = modeWord;
            end
            stActive:
            begin
                cmdBus.cmd  = cmdActive;
                cmdBus.addr = row;
                cmdBus.ba   = bank;
            end
            stWrite, stRead:
            begin
                cmdBus.cmd  = (state == stWrite) ? cmdWrite : cmdRead;
                cmdBus.addr = {3'b000, col};        // A10 low, precharge done by hand
                cmdBus.ba   = bank;
            end
            default:
                cmdBus.cmd = cmdNop;
        endcase
    end

    assign refreshAck    = (state == stRefRef);     // Periodic refresh only
    assign write         = reqLatch.write;
    assign wrData        = reqLatch.wrData;
    assign byteEn        = reqLatch.byteEn;
    assign burstPhase    = (state == stWrite)
                           || (state == stBurst && reqLatch.write && beat < lastWriteBeat);
    assign captureStrobe = (state == stBurst) && !reqLatch.write && beat >= firstCapture;
    assign byteIndex     = reqLatch.write ? beat[1:0] : 2'(beat - firstCapture);

    // Column access only into the row opened trcd NOPs before
    rowOpenBeforeAccess: assert property (@(posedge clk) disable iff (!RESETn)
        (cmdBus.cmd inside {cmdRead, cmdWrite}) |->
            $past(cmdBus.cmd, timing.trcd + 1) == cmdActive
            && $past(cmdBus.ba, timing.trcd + 1) == cmdBus.ba)
        else $error("sdramSequencer: column access to bank %0d without ACTIVE", cmdBus.ba);

    nopWhileCkeLow: assert property (@(posedge clk) disable iff (!RESETn)
        !cmdBus.cke |-> cmdBus.cmd == cmdNop)
        else $error("sdramSequencer: %s issued with cke low", cmdBus.cmd.name());

endmodule

/* src/refreshTimer.sv */
`timescale 1ns/100ps

module refreshTimer #(
    parameter sdramPkg::sdramTimingT timing = sdramPkg::defaultTiming
) (
    input  logic clk,
    input  logic RESETn,
    input  logic enable,                        // High once init is complete
    input  logic ack,                           // Periodic AREFRESH going out
    output logic refreshDue
);

    logic [15:0] elapsed;                       // Cycles since enable or last ack

    always_ff @(posedge clk)
    begin
        if (!RESETn || !enable)
        begin
            elapsed    <= '0;
            refreshDue <= 1'b0;
        end
        else if (ack)
        begin
            elapsed    <= 16'd1;                // Ack cycle is the first of the interval
            refreshDue <= 1'b0;
        end
        else if (!refreshDue)
        begin
            elapsed <= elapsed + 16'd1;
            if (elapsed == timing.refreshInterval - 16'd1)
            begin
                refreshDue <= 1'b1;             // Held until the sequencer gets to it
            end
        end
    end

    // Sequencer acks only a refresh it was asked for
    ackWithoutDue: assert property (@(posedge clk) disable iff (!RESETn)
        ack |-> refreshDue)
        else $error("refreshTimer: ack while no refresh is due");

endmodule

/* src/delayTimer.sv */
`timescale 1ns/100ps

module delayTimer (
    input  logic        clk,
    input  logic        RESETn,
    input  logic        load,                   // Start strobe, one cycle
    input  logic [15:0] count,                  // Wait length in cycles, nonzero
    output logic        done
);

    logic [15:0] remaining;                     // Zero when no wait is open

    always_ff @(posedge clk)
    begin
        if (!RESETn)
        begin
            remaining <= '0;
        end
        else if (load)
        begin
            remaining <= count;
        end
        else if (remaining != '0)
        begin
            remaining <= remaining - 16'd1;
        end
    end

    assign done = (remaining == 16'd1);         // Last cycle of the wait

    // Sequencer only reloads once the previous gap has fully run out
    loadWhileBusy: assert property (@(posedge clk) disable iff (!RESETn)
        load |-> remaining == '0)
        else $error("delayTimer: load with %0d cycles still pending", remaining);

endmodule

/* src/hostBusPkg.sv */
package hostBusPkg;

    typedef logic [29:0] hostAddrT;             // Word address, byte offset dropped
    typedef logic [31:0] hostWordT;             // Host data word
    typedef logic [3:0]  byteEnT;               // One enable per lane, high active

    // One host access, held steady by the host until ready
    typedef struct packed {
        logic     write;                        // High write, low read
        hostAddrT addr;
        byteEnT   byteEn;                       // Don't care on reads
        hostWordT wrData;
    } hostReqT;

endpackage

/* src/sdramPkg.sv */
package sdramPkg;

    // Command triple as driven on {WEn, RASn, CASn}
    typedef enum logic [2:0] {
        cmdNop         = 3'b111,
        cmdPrecharge   = 3'b001,
        cmdLmr         = 3'b000,
        cmdAutoRefresh = 3'b100,
        cmdActive      = 3'b101,
        cmdWrite       = 3'b010,
        cmdRead        = 3'b110
    } sdramCmdT;

    typedef logic [1:0]  bankT;                 // Bank select
    typedef logic [11:0] rowT;                  // Row address
    typedef logic [8:0]  colT;                  // Column address, byte granular
    typedef logic [7:0]  dqT;                   // One SDRAM data byte

    // Everything the sequencer puts on the command pins
    typedef struct packed {
        logic        cke;                       // Clock enable
        sdramCmdT    cmd;
        logic [11:0] addr;                      // Row, column or mode word
        bankT        ba;
    } sdramCmdBusT;

    // Full SDRAM control bus, the byte mask appended last
    typedef struct packed {
        logic        cke;
        sdramCmdT    cmd;
        logic [11:0] addr;
        bankT        ba;
        logic        dqm;                       // High masks the current write byte
    } sdramBusT;

    localparam int casLatency = 2;              // READ to first data byte
    localparam int burstBytes = 4;              // One host word per burst

    // BL 4, sequential, CL 2, burst writes
    localparam logic [11:0] modeWord = 12'b0000_0010_0010;

    typedef struct packed {
        logic [15:0] initWait;                  // Power-up wait with cke low
        logic [15:0] trp;                       // PRECHARGE period
        logic [15:0] trfc;                      // AREFRESH period
        logic [15:0] tmrd;                      // LMR to next command
        logic [15:0] trcd;                      // ACTIVE to READ/WRITE
        logic [15:0] refreshInterval;           // Between periodic refreshes
    } sdramTimingT;

    // Cycle counts for a 10 ns clock
    localparam sdramTimingT defaultTiming = '{
        initWait:        16'd10000,             // 100 us
        trp:             16'd2,
        trfc:            16'd7,
        tmrd:            16'd2,
        trcd:            16'd2,
        refreshInterval: 16'd1563               // 15.625 us per row
    };

endpackage
